// ==== filelist.f ====
+incdir+.
routerPkg.sv
inputBuffer.sv
grantTimer.sv
switchArbiter.sv
outputPort.sv
routerChannel.sv
routerChannelTb.sv

// ==== Bender.yml ====
package:
  name: router_channel

export_include_dirs:
  - .

sources:
  - files:
      - routerPkg.sv
      - inputBuffer.sv
      - grantTimer.sv
      - switchArbiter.sv
      - outputPort.sv
      - routerChannel.sv
  - target: test
    files:
      - routerChannelTb.sv

// ==== routerChannelTb.sv ====
`include "router_defines.svh"

module routerChannelTb;
  timeunit 1ns;
  timeprecision 100ps;
  import routerPkg::*;

  typedef struct packed {
    logic [3:0] testNo;
    portT       port;
    logic [7:0] start;   // Cycle after test start when the port begins sending.
    lengthT     declLen; // Length written into the head flit.
    logic [7:0] flits;   // Flits actually sent.
    logic [7:0] tag;
  } rowT;

  localparam int numRows = 12;
  localparam int numTests = 5;

  // Packets of one port in one test go out back to back.
  localparam rowT rows [numRows] = '{
    '{4'd1, NORTH, 8'd0, 12'd4, 8'd4, 8'h11},
    '{4'd2, LOCAL, 8'd0, 12'd3, 8'd3, 8'h21},
    '{4'd2, NORTH, 8'd0, 12'd3, 8'd3, 8'h22},
    '{4'd2, EAST, 8'd0, 12'd3, 8'd3, 8'h23},
    '{4'd2, WEST, 8'd0, 12'd3, 8'd3, 8'h24},
    '{4'd2, SOUTH, 8'd0, 12'd3, 8'd3, 8'h25},
    '{4'd3, LOCAL, 8'd0, 12'd5, 8'd5, 8'h31},
    '{4'd3, LOCAL, 8'd0, 12'd5, 8'd5, 8'h32},
    '{4'd3, EAST, 8'd4, 12'd4, 8'd4, 8'h33},
    '{4'd4, SOUTH, 8'd0, 12'd8, 8'd8, 8'h41},
    '{4'd5, NORTH, 8'd0, 12'd2, 8'd5, 8'h51},
    '{4'd5, WEST, 8'd0, 12'd3, 8'd3, 8'h52}
  };

  // Cycles from test start during which downstream keeps its credits.
  localparam int holdFor [numTests + 1] = '{0, 0, 0, 0, 30, 0};

  logic clk = 1'b0;
  logic rst = 1'b1;
  flitT inFlit [`NUM_PORTS] = '{default: '0};
  logic [`NUM_PORTS-1:0] inValid = '0;
  logic [`NUM_PORTS-1:0] inCredit;
  flitT outFlit;
  logic outValid;
  logic outCredit = 1'b0;

  integer seed = 32'hd574ce46;
  flitT txQ [`NUM_PORTS][$];
  flitT predQ [`NUM_PORTS][$];
  flitT expOut [$];
  int startAt [`NUM_PORTS];
  int credits [`NUM_PORTS];
  int creditSeen [`NUM_PORTS];
  int owed = 0;
  int rxCount = 0;
  int holdSeen = 0;
  int holdUntil = 0;
  int cycle = 0;
  int testBase = 0;
  int cycleLimit = 0;
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;

  routerChannel dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inCredit (inCredit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outCredit(outCredit)
  );

  always #50 clk = ~clk;

  // Upstream senders and the downstream receiver.
  always @(posedge clk)
  begin
    int testCycle;
    flitT expFlit;
    testCycle = cycle - testBase;
    cycle = cycle + 1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (rst)
      begin
        credits[p] = `BUF_DEPTH;
        inValid[p] <= 1'b0;
      end
      else
      begin
        if (inCredit[p])
        begin
          credits[p]++;
          creditSeen[p]++;
        end
        if ((txQ[p].size() > 0) && (credits[p] > 0) && (testCycle >= startAt[p]))
        begin
          inFlit[p] <= txQ[p].pop_front();
          inValid[p] <= 1'b1;
          credits[p]--;
        end
        else
        begin
          inValid[p] <= 1'b0;
        end
      end
    end
    if (rst)
    begin
      owed = 0;
      outCredit <= 1'b0;
    end
    else
    begin
      if (outValid)
      begin
        rxCount++;
        owed++;
        if (testCycle < holdUntil)
        begin
          holdSeen++;
        end
        if (expOut.size() == 0)
        begin
          $display("Flit %h arrived at %0t but none was expected", outFlit, $time);
          errors++;
        end
        else
        begin
          expFlit = expOut.pop_front();
          if (outFlit !== expFlit)
          begin
            $display("CHECK FAILED at %0t: outFlit expected %h got %h", $time, expFlit, outFlit);
            errors++;
          end
        end
      end
      if ((owed > 0) && (testCycle >= holdUntil))
      begin
        outCredit <= 1'b1; // One slot freed downstream.
        owed--;
      end
      else
      begin
        outCredit <= 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (cycle >= cycleLimit)
    begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic string testName(input int t);
    case (t)
      1: return "single packet";
      2: return "all ports at once";
      3: return "rotation";
      4: return "back-pressure";
      5: return "timer cutoff";
      default: return "reset values";
    endcase
  endfunction

  function automatic logic linksIdle();
    logic idle;
    idle = (owed == 0);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if ((txQ[p].size() != 0) || (credits[p] != `BUF_DEPTH))
      begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic makePacket(input int r);
    flitT f;
    int p;
    integer rnd;
    p = int'(rows[r].port);
    for (int i = 0; i < int'(rows[r].flits); i++)
    begin
      rnd = $random(seed);
      if (i == 0)
      begin
        f.id = HEAD;
        f.data = (payloadT'(r) << `LEN_W) | payloadT'(rows[r].declLen);
      end
      else
      begin
        f.id = (i == int'(rows[r].flits) - 1) ? TAIL : BODY;
        f.data = {rows[r].tag, rnd[7:0]};
      end
      txQ[p].push_back(f);
    end
  endtask

  // Predicts the grant order from idle priority and rotation after the owner.
  task automatic predictOrder();
    lengthT latched [`NUM_PORTS];
    int owner;
    int pick;
    int idx;
    int now;
    int n;
    int left;
    expOut.delete();
    left = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      predQ[p] = txQ[p];
      latched[p] = '0;
      left += predQ[p].size();
    end
    owner = -1;
    now = 0;
    while (left > 0)
    begin
      pick = -1;
      for (int k = 1; (owner >= 0) && (k < `NUM_PORTS); k++)
      begin
        idx = (owner + k) % `NUM_PORTS;
        if ((pick < 0) && (predQ[idx].size() > 0) && (startAt[idx] <= now))
        begin
          pick = idx;
        end
      end
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        if ((pick < 0) && (predQ[k].size() > 0) && (startAt[k] <= now))
        begin
          pick = k;
        end
      end
      if (pick < 0)
      begin
        owner = -1;
        now++;
      end
      else
      begin
        if (predQ[pick][0].id == HEAD)
        begin
          latched[pick] = predQ[pick][0].data[`LEN_W-1:0];
        end
        n = 0;
        while ((n < int'(latched[pick])) && (predQ[pick].size() > 0))
        begin
          expOut.push_back(predQ[pick].pop_front());
          n++;
        end
        left -= n;
        now += n + 2;
        owner = pick;
      end
    end
  endtask

  task automatic checkResetOutputs();
    if (outValid !== 1'b0)
    begin
      $display("CHECK FAILED at %0t: outValid expected 0 got %b", $time, outValid);
      errors++;
    end
    if (inCredit !== '0)
    begin
      $display("CHECK FAILED at %0t: inCredit expected 00000 got %b", $time, inCredit);
      errors++;
    end
  endtask

  task automatic reportTest(input int t, input int errBefore);
    testsRun++;
    if (errors != errBefore)
    begin
      testsFailed++;
    end
    $display("Test %0d %s: %s", t, testName(t), (errors == errBefore) ? "passed" : "failed");
  endtask

  task automatic runTest(input int t);
    int errBefore;
    int expCount;
    int portFlits [`NUM_PORTS];
    int expHold;
    errBefore = errors;
    @(negedge clk);
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      startAt[p] = -1;
      portFlits[p] = 0;
      creditSeen[p] = 0;
    end
    for (int r = 0; r < numRows; r++)
    begin
      if (int'(rows[r].testNo) == t)
      begin
        if (startAt[rows[r].port] < 0)
        begin
          startAt[rows[r].port] = int'(rows[r].start);
        end
        portFlits[rows[r].port] += int'(rows[r].flits);
        makePacket(r);
      end
    end
    predictOrder();
    expCount = expOut.size();
    rxCount = 0;
    holdSeen = 0;
    holdUntil = holdFor[t];
    testBase = cycle;
    while ((rxCount < expCount) || !linksIdle())
    begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk); // Room for a stray flit to show up.
    if (rxCount != expCount)
    begin
      $display("CHECK FAILED at %0t: outValid count expected %0d got %0d",
               $time, expCount, rxCount);
      errors++;
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (creditSeen[p] != portFlits[p])
      begin
        $display("CHECK FAILED at %0t: inCredit[%0d] pulses expected %0d got %0d",
                 $time, p, portFlits[p], creditSeen[p]);
        errors++;
      end
    end
    if (holdFor[t] > 0)
    begin
      expHold = (expCount < `BUF_DEPTH) ? expCount : `BUF_DEPTH;
      if (holdSeen != expHold)
      begin
        $display("CHECK FAILED at %0t: outValid during back-pressure expected %0d got %0d",
                 $time, expHold, holdSeen);
        errors++;
      end
    end
    reportTest(t, errBefore);
  endtask

  initial
  begin
    int errBefore;
    cycleLimit = 200;
    for (int r = 0; r < numRows; r++)
    begin
      cycleLimit += 20 * int'(rows[r].flits);
    end
    errBefore = errors;
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      checkResetOutputs();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      checkResetOutputs();
    end
    reportTest(6, errBefore);
    for (int t = 1; t <= numTests; t++)
    begin
      runTest(t);
    end
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             testsRun, testsRun - testsFailed, testsFailed, errors);
    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== routerChannel.sv ====
`include "router_defines.svh"

module routerChannel (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitT       inFlit [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] inValid,
  output logic [`NUM_PORTS-1:0] inCredit,
  output routerPkg::flitT       outFlit,
  output logic                  outValid,
  input  logic                  outCredit
);
  import routerPkg::*;

  logic [`NUM_PORTS-1:0] req;
  logic [`NUM_PORTS-1:0] fwd;
  flitT headFlit [`NUM_PORTS];
  logic canSend;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genInput
    inputBuffer bufInst (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[p]),
      .inValid (inValid[p]),
      .inCredit(inCredit[p]),
      .req     (req[p]),
      .headFlit(headFlit[p]),
      .pop     (fwd[p]) // Granted buffer drains on forward.
    );
  end

  switchArbiter arbInst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .headFlit(headFlit),
    .canSend (canSend),
    .grant   (),
    .fwd     (fwd)
  );

  outputPort outInst (
    .clk      (clk),
    .rst      (rst),
    .bufFlit  (headFlit),
    .fwd      (fwd),
    .canSend  (canSend),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outCredit(outCredit)
  );

endmodule

// ==== outputPort.sv ====
`include "router_defines.svh"

module outputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitT       bufFlit [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] fwd,
  output logic                  canSend,
  output routerPkg::flitT       outFlit,
  output logic                  outValid,
  input  logic                  outCredit
);
  import routerPkg::*;

  localparam int creditW = $clog2(`BUF_DEPTH + 1);

  logic [creditW-1:0] credits;
  flitT selFlit;
  logic sending;

  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (fwd[p])
      begin
        selFlit = bufFlit[p];
      end
    end
  end

  assign sending = |fwd;
  assign canSend = (credits != '0);

  always_ff @(posedge clk)
  begin
    if (sending)
    begin
      outFlit <= selFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      credits <= creditW'(`BUF_DEPTH); // Downstream buffer starts empty.
    end
    else
    begin
      outValid <= sending;
      case ({sending, outCredit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // A credit beyond the downstream depth means the far side miscounted.
  assert property (@(posedge clk) disable iff (rst) credits <= `BUF_DEPTH)
  else
    $error("outputPort: credit count above buffer depth");

  assert property (@(posedge clk) disable iff (rst) sending |-> canSend)
  else
    $error("outputPort: flit forwarded without a credit");

endmodule

// ==== switchArbiter.sv ====
`include "router_defines.svh"

module switchArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  routerPkg::flitT       headFlit [`NUM_PORTS],
  input  logic                  canSend,
  output logic [`NUM_PORTS-1:0] grant,
  output logic [`NUM_PORTS-1:0] fwd
);
  import routerPkg::*;

  arbStateT state;
  arbStateT nextState;
  portT owner;
  logic holdGrant;
  logic [`NUM_PORTS-1:0] load;
  logic [`NUM_PORTS-1:0] timesUp;

  // First requester found from start onward, wrapping, over span ports.
  function automatic arbStateT rotatePick(
    input logic [`NUM_PORTS-1:0] reqs,
    input int unsigned           start,
    input int unsigned           span
  );
    arbStateT pick;
    int unsigned idx;
    pick = IDLE;
    for (int unsigned k = 0; k < span; k++)
    begin
      idx = (start + k) % `NUM_PORTS;
      if ((pick == IDLE) && reqs[idx])
      begin
        pick = arbStateT'(6'b000010 << idx);
      end
    end
    return pick;
  endfunction

  assign grant = state[`NUM_PORTS:1];

  always_comb
  begin
    owner = LOCAL;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        owner = portT'(p);
      end
    end
  end

  assign holdGrant = (state != IDLE) && req[owner] && !timesUp[owner];

  always_comb
  begin
    case (state)
      IDLE:
      begin
        nextState = rotatePick(req, int'(LOCAL), `NUM_PORTS); // Fixed priority.
      end
      GRANT_L, GRANT_N, GRANT_E, GRANT_W, GRANT_S:
      begin
        if (holdGrant)
        begin
          nextState = state;
        end
        else
        begin
          // Owner is skipped and goes last.
          nextState = rotatePick(req, int'(owner) + 1, `NUM_PORTS - 1);
        end
      end
      default:
      begin
        nextState = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign load = nextState[`NUM_PORTS:1] & ~state[`NUM_PORTS:1]; // Grant being entered.
  assign fwd = grant & req & ~timesUp & {`NUM_PORTS{canSend}};

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    grantTimer timerInst (
      .clk     (clk),
      .rst     (rst),
      .headFlit(headFlit[p]),
      .load    (load[p]),
      .run     (fwd[p]),
      .timesUp (timesUp[p])
    );
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
  else
    $error("switchArbiter: state is not one-hot");

endmodule

// ==== grantTimer.sv ====
`include "router_defines.svh"

module grantTimer (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT headFlit,
  input  logic            load,
  input  logic            run,
  output logic            timesUp
);
  import routerPkg::*;

  lengthT length;
  lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      length <= '0;
      count <= '0;
    end
    else if (load)
    begin
      if (headFlit.id == HEAD)
      begin
        length <= lengthT'(headFlit.data[`LEN_W-1:0]);
      end
      count <= '0; // Each new grant starts from zero.
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
  end

  assign timesUp = (count == length);

endmodule

// ==== inputBuffer.sv ====
`include "router_defines.svh"

module inputBuffer (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT inFlit,
  input  logic            inValid,
  output logic            inCredit,
  output logic            req,
  output routerPkg::flitT headFlit,
  input  logic            pop
);
  import routerPkg::*;

  localparam int ptrW = $clog2(`BUF_DEPTH);

  flitT mem [`BUF_DEPTH];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0] count;
  logic doPop;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(`BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req = (count != '0);
  assign headFlit = mem[rdPtr];
  assign doPop = pop && req; // Ignore a pop on an empty buffer.

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inCredit <= 1'b0;
    end
    else
    begin
      if (inValid)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({inValid, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      inCredit <= doPop; // Freed slot goes back upstream.
    end
  end

  // Upstream must never send without a credit in hand.
  assert property (@(posedge clk) disable iff (rst)
    inValid |-> (count < `BUF_DEPTH))
  else
    $error("inputBuffer: write into a full buffer");

endmodule

// ==== routerPkg.sv ====
`include "router_defines.svh"

package routerPkg;

  typedef logic [`PAYLOAD_W-1:0] payloadT;
  typedef logic [`LEN_W-1:0] lengthT; // Packet length in flits.

  typedef enum logic [2:0] {
    HEAD = 3'b001,
    BODY = 3'b010,
    TAIL = 3'b100
  } flitIdT;

  typedef struct packed {
    flitIdT id;
    payloadT data; // Head flit keeps the length in the low bits.
  } flitT;

  // Order here is also the fixed idle priority.
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST = 3'd2,
    WEST = 3'd3,
    SOUTH = 3'd4
  } portT;

  // Bit n+1 of a grant state matches port n.
  typedef enum logic [5:0] {
    IDLE = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbStateT;

endpackage

// ==== router_defines.svh ====
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Slots per input buffer, also the starting credit count of every link.
`define BUF_DEPTH 4

// Flit payload width in bits.
`define PAYLOAD_W 16

// Packet length field carried in the low bits of a head flit.
`define LEN_W 12

// Local, North, East, West, South.
`define NUM_PORTS 5

`endif
